// ==== Bender.yml ====
package:
  name: uart_rx

sources:
  - files:
      - uart_rx_pkg.sv
      - rx_fifo_rd_if.sv
      - uart_rx_sampler.sv
      - uart_rx_fifo.sv
      - uart_rx_apb.sv
      - uart_rx_top.sv
  - target: test
    files:
      - tb_uart_rx.sv

// ==== rx_fifo_rd_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface rx_fifo_rd_if;
	import uart_rx_pkg::*;

	logic               pop;
	logic [ENTRY_W-1:0] rdata;         // head entry, show-ahead
	logic               empty;
	logic [LEVEL_W-1:0] level;
	logic               overrun;
	logic               overrun_clr;

	modport fifo (
		input  pop, overrun_clr,
		output rdata, empty, level, overrun
	);

	modport reader (
		output pop, overrun_clr,
		input  rdata, empty, level, overrun
	);

endinterface

`default_nettype wire

// ==== tb_uart_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_uart_rx;
	import uart_rx_pkg::*;

	localparam int HALF_PERIOD = 20;
	localparam int WAIT_LIMIT  = 40 * OVERSAMPLE;  // 40 bit times in cycles

	logic        baud_rx_clock;
	logic        i_reset;
	logic        i_rx;
	logic        i_psel;
	logic        i_penable;
	logic        i_pwrite;
	logic [3:0]  i_paddr;
	logic [31:0] i_pwdata;
	wire  [31:0] o_prdata;
	wire         o_pready;
	wire         o_pslverr;

	logic [31:0]        lfsr;
	logic [ENTRY_W-1:0] model_q [$];   // {frame_err, byte}
	logic               model_ovr;

	uart_rx_top u_dut (
		.baud_rx_clock (baud_rx_clock),
		.i_reset       (i_reset),
		.i_rx          (i_rx),
		.i_psel        (i_psel),
		.i_penable     (i_penable),
		.i_pwrite      (i_pwrite),
		.i_paddr       (i_paddr),
		.i_pwdata      (i_pwdata),
		.o_prdata      (o_prdata),
		.o_pready      (o_pready),
		.o_pslverr     (o_pslverr)
	);

	always #HALF_PERIOD baud_rx_clock = ~baud_rx_clock;

	// fibonacci lfsr with taps 32 22 2 1
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] val;
		logic        fb;
		int          i;
		val = '0;
		for (i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			val  = {val[30:0], fb};
		end
		return val;
	endfunction

	task automatic fail_now(input string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1, "run stopped on first error");
	endtask

	task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			fail_now($sformatf("[ERROR] %0t: %s, got 0x%0h, expected 0x%0h",
				$time, what, actual, expected));
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(negedge baud_rx_clock);
	endtask

	task automatic push_model(input logic [ENTRY_W-1:0] entry);
		if (model_q.size() == FIFO_DEPTH) begin
			model_ovr = 1'b1;              // full fifo drops the byte
		end else begin
			model_q.push_back(entry);
		end
	endtask

	// ====================
	// serial driver
	task automatic send_frame(input logic [7:0] data, input logic stop);
		logic [9:0] bits;
		int         b;
		bits = {stop, data, 1'b0};
		for (b = 0; b < 10; b++) begin
			@(negedge baud_rx_clock);
			i_rx = bits[b];
			idle_cycles(OVERSAMPLE - 1);
		end
		@(negedge baud_rx_clock);
		i_rx = 1'b1;
		push_model({~stop, data});
		// a low stop is still low when the fsm goes idle, so it frames
		// an extra byte of all ones from the idle line
		if (!stop) begin
			idle_cycles(10 * OVERSAMPLE);
			push_model({1'b0, 8'hff});
		end
	endtask

	task automatic send_random_frame(input logic stop);
		logic [7:0] data;
		data = take_bits(8);
		send_frame(data, stop);
	endtask

	// ====================
	// apb requester
	task automatic apb_access(input logic wr, input logic [3:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		@(negedge baud_rx_clock);
		i_psel   = 1'b1;
		i_pwrite = wr;
		i_paddr  = addr;
		i_pwdata = wdata;
		@(negedge baud_rx_clock);
		i_penable = 1'b1;
		#(HALF_PERIOD / 2);                // mid access cycle
		rdata = o_prdata;
		err   = o_pslverr;
		check_eq(32'(o_pready), 32'd1, "pready in access cycle");
		@(negedge baud_rx_clock);
		i_psel    = 1'b0;
		i_penable = 1'b0;
	endtask

	task automatic apb_read(input logic [3:0] addr, output logic [31:0] data,
			output logic err);
		apb_access(1'b0, addr, 32'd0, data, err);
	endtask

	task automatic apb_write(input logic [3:0] addr, input logic [31:0] data,
			output logic err);
		logic [31:0] unused;
		apb_access(1'b1, addr, data, unused, err);
	endtask

	task automatic read_rxdata_checked();
		logic [31:0] data;
		logic [31:0] expected;
		logic        err;
		apb_read(ADDR_RXDATA, data, err);
		check_eq(32'(err), 32'd0, "pslverr on RXDATA read");
		if (model_q.size() == 0) begin
			expected = '0;                 // empty so valid stays low
		end else begin
			expected = 32'h200 | 32'(model_q.pop_front());
		end
		check_eq(data, expected, "RXDATA read");
	endtask

	task automatic check_status();
		logic [31:0] data;
		logic        err;
		apb_read(ADDR_STATUS, data, err);
		check_eq(32'(err), 32'd0, "pslverr on STATUS read");
		check_eq(data, {23'd0, model_ovr, 2'b00, LEVEL_W'(model_q.size())}, "STATUS read");
	endtask

	task automatic wait_for_level(input int n);
		logic [31:0] data;
		logic        err;
		int          waited;
		waited = 0;
		apb_read(ADDR_STATUS, data, err);
		while (data[LEVEL_W-1:0] != LEVEL_W'(n)) begin
			if (waited >= WAIT_LIMIT) begin
				fail_now($sformatf("timeout: no byte arrived, level %0d, wanted %0d",
					data[LEVEL_W-1:0], n));
			end else begin
				apb_read(ADDR_STATUS, data, err);
				waited += 3;               // cycles per poll
			end
		end
	endtask

	initial begin
		logic [31:0] data;
		logic        err;
		int          n;
		int          i;
		baud_rx_clock = 1'b0;
		i_reset       = 1'b1;
		i_rx          = 1'b1;
		i_psel        = 1'b0;
		i_penable     = 1'b0;
		i_pwrite      = 1'b0;
		i_paddr       = '0;
		i_pwdata      = '0;
		lfsr          = 32'h44fa;
		model_ovr     = 1'b0;
		idle_cycles(3);
		i_reset = 1'b0;
		idle_cycles(2);
		check_status();

		// ==================== random frames and reads
		for (i = 0; i < 60; i++) begin
			send_random_frame(take_bits(3) != 0);  // about 1 in 8 with low stop
			idle_cycles(take_bits(5));
			wait_for_level(model_q.size());
			n = take_bits(2);
			while (n > 0 && model_q.size() > 0) begin
				read_rxdata_checked();
				n--;
			end
		end
		while (model_q.size() > 0) begin
			read_rxdata_checked();
		end
		apb_write(ADDR_STATUS, 32'h100, err);
		model_ovr = 1'b0;
		check_status();

		// low stop then a clean frame
		send_frame(8'h5a, 1'b0);
		send_frame(8'hc3, 1'b1);
		wait_for_level(3);
		repeat (3) read_rxdata_checked();

		// ==================== level count
		n = take_bits(5);
		repeat (n) send_random_frame(1'b1);
		wait_for_level(n);
		check_status();
		repeat (n) begin
			read_rxdata_checked();
			check_status();
		end
		read_rxdata_checked();

		// ==================== overrun
		repeat (34) send_random_frame(1'b1);
		wait_for_level(FIFO_DEPTH);
		check_status();
		repeat (FIFO_DEPTH) read_rxdata_checked();

		// illegal accesses leave level and overrun alone
		repeat (2) send_random_frame(1'b1);
		wait_for_level(2);
		apb_read(4'h8, data, err);
		check_eq(32'(err), 32'd1, "pslverr on read of address 0x8");
		apb_write(ADDR_RXDATA, 32'h1ff, err);
		check_eq(32'(err), 32'd1, "pslverr on RXDATA write");
		apb_write(4'h8, 32'h100, err);
		check_eq(32'(err), 32'd1, "pslverr on write of address 0x8");
		check_status();
		apb_write(ADDR_STATUS, 32'h100, err);
		check_eq(32'(err), 32'd0, "pslverr on STATUS write");
		model_ovr = 1'b0;
		check_status();
		repeat (2) read_rxdata_checked();

		// ==================== glitch on the idle line
		@(negedge baud_rx_clock);
		i_rx = 1'b0;
		idle_cycles(3);
		i_rx = 1'b1;
		idle_cycles(2 * OVERSAMPLE);
		check_status();
		idle_cycles(10 * OVERSAMPLE);      // a wrongly accepted start would have pushed by now
		check_status();

		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

// ==== uart_rx_apb.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_rx_apb (
	input  wire                                           baud_rx_clock,
	input  wire                                           i_reset,
	input  wire                                           i_psel,
	input  wire                                           i_penable,
	input  wire                                           i_pwrite,
	input  wire  [$bits(uart_rx_pkg::ADDR_RXDATA)-1:0]    i_paddr,
	input  wire  [31:0]                                   i_pwdata,
	output logic [31:0]                                   o_prdata,
	output logic                                          o_pready,
	output logic                                          o_pslverr,
	rx_fifo_rd_if.reader                                  rd
);
	import uart_rx_pkg::*;

	logic access;
	logic acc_q;
	logic acc_first;
	logic rd_rxdata;
	logic rd_status;
	logic wr_status;

	// ====================
	// access decode
	assign access    = i_psel && i_penable;
	assign acc_first = access && !acc_q;  // side effects fire once per transfer
	assign rd_rxdata = access && !i_pwrite && (i_paddr == ADDR_RXDATA);
	assign rd_status = access && !i_pwrite && (i_paddr == ADDR_STATUS);
	assign wr_status = access && i_pwrite && (i_paddr == ADDR_STATUS);

	always_ff @(posedge baud_rx_clock) begin
		if (i_reset) begin
			acc_q <= 1'b0;
		end else begin
			acc_q <= access;
		end
	end

	assign o_pready  = 1'b1;  // no wait states
	assign o_pslverr = access && !(rd_rxdata || rd_status || wr_status);

	// ====================
	// fifo side
	assign rd.pop         = rd_rxdata && acc_first && !rd.empty;
	assign rd.overrun_clr = wr_status && acc_first && i_pwdata[8];

	// read data, zero outside a legal read
	always_comb begin
		o_prdata = '0;
		if (rd_rxdata && !rd.empty) begin
			o_prdata = 32'({1'b1, rd.rdata});            // valid, frame_err, byte
		end else if (rd_status) begin
			o_prdata = 32'({rd.overrun, 2'b00, rd.level});
		end
	end

endmodule

`default_nettype wire

// ==== uart_rx_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_rx_fifo (
	input  wire        baud_rx_clock,
	input  wire        i_reset,
	input  wire        i_push,
	input  wire  [7:0] i_byte,
	input  wire        i_frame_err,
	rx_fifo_rd_if.fifo rd
);
	import uart_rx_pkg::*;

	logic [ENTRY_W-1:0] mem [FIFO_DEPTH];
	logic [FIFO_AW-1:0] wr_ptr;
	logic [FIFO_AW-1:0] rd_ptr;
	logic [LEVEL_W-1:0] level;
	logic               overrun;
	logic               full;
	logic               empty;
	logic               do_push;
	logic               do_pop;

	assign full    = (level == LEVEL_W'(FIFO_DEPTH));
	assign empty   = (level == '0);
	assign do_push = i_push && !full;  // a push while full is lost
	assign do_pop  = rd.pop && !empty;

	always_ff @(posedge baud_rx_clock) begin
		if (do_push) begin
			mem[wr_ptr] <= {i_frame_err, i_byte};
		end
	end

	// ====================
	// pointers and level
	always_ff @(posedge baud_rx_clock) begin
		if (i_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;   // depth is a power of two
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   level <= level + 1'b1;
				2'b01:   level <= level - 1'b1;
				default: level <= level;
			endcase
		end
	end

	// sticky until cleared, a new overrun wins over the clear
	always_ff @(posedge baud_rx_clock) begin
		if (i_reset) begin
			overrun <= 1'b0;
		end else if (i_push && full) begin
			overrun <= 1'b1;
		end else if (rd.overrun_clr) begin
			overrun <= 1'b0;
		end
	end

	assign rd.rdata   = mem[rd_ptr];
	assign rd.empty   = empty;
	assign rd.level   = level;
	assign rd.overrun = overrun;

endmodule

`default_nettype wire

// ==== uart_rx_pkg.sv ====
`default_nettype none

package uart_rx_pkg;

	// ====================
	// serial timing
	localparam int OVERSAMPLE = 16;    // baud_rx_clock ticks per bit
	localparam int MID_SAMPLE = 7;     // start bit recheck point
	localparam int DATA_BITS  = 8;

	// ====================
	// receive buffer
	localparam int FIFO_DEPTH = 32;
	localparam int FIFO_AW    = 5;
	localparam int LEVEL_W    = 6;     // counts 0..FIFO_DEPTH
	localparam int ENTRY_W    = 9;     // {frame_err, data}

	// ====================
	// register map
	localparam logic [3:0] ADDR_RXDATA = 4'h0;
	localparam logic [3:0] ADDR_STATUS = 4'h4;

	typedef enum logic [1:0] {
		IDLE  = 2'b00,
		START = 2'b01,
		DATA  = 2'b10,
		STOP  = 2'b11
	} rx_state_t;

endpackage

`default_nettype wire

// ==== uart_rx_sampler.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_rx_sampler (
	input  wire        baud_rx_clock,
	input  wire        i_reset,
	input  wire        i_rx,
	output logic       o_push,
	output logic [7:0] o_byte,
	output logic       o_frame_err
);
	import uart_rx_pkg::*;

	logic                 rx_meta;
	logic                 rx_sync;
	rx_state_t            state;
	logic [3:0]           tick;
	logic [2:0]           bit_idx;
	logic [DATA_BITS-1:0] shift;
	logic                 bit_tick;

	// ====================
	// line synchronizer
	always_ff @(posedge baud_rx_clock) begin
		if (i_reset) begin
			rx_meta <= 1'b1;               // idle line is high
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= i_rx;
			rx_sync <= rx_meta;
		end
	end

	assign bit_tick = (tick == 4'(OVERSAMPLE - 1));

	// ====================
	// frame FSM
	always_ff @(posedge baud_rx_clock) begin
		if (i_reset) begin
			state   <= IDLE;
			tick    <= '0;
			bit_idx <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (!rx_sync) begin
						state <= START;
						tick  <= 4'd1;         // the edge cycle is tick 0
					end
				end
				START: begin
					if (tick == 4'(MID_SAMPLE)) begin
						tick    <= '0;
						bit_idx <= '0;
						if (rx_sync) begin
							state <= IDLE;     // glitch, line went back high
						end else begin
							state <= DATA;
						end
					end else begin
						tick <= tick + 4'd1;
					end
				end
				DATA: begin
					tick <= tick + 4'd1;       // wraps to 0 after each sample
					if (bit_tick) begin
						bit_idx <= bit_idx + 3'd1;
						if (bit_idx == 3'(DATA_BITS - 1)) begin
							state <= STOP;
						end
					end
				end
				STOP: begin
					tick <= tick + 4'd1;
					if (bit_tick) begin
						state <= IDLE;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// lsb arrives first, so shift in from the top
	always_ff @(posedge baud_rx_clock) begin
		if (state == DATA && bit_tick) begin
			shift <= {rx_sync, shift[DATA_BITS-1:1]};
		end
	end

	// ====================
	// byte out
	assign o_push      = (state == STOP) && bit_tick;  // stop sample cycle
	assign o_byte      = shift;
	assign o_frame_err = !rx_sync;                     // stop bit must be high

endmodule

`default_nettype wire

// ==== uart_rx_top.f ====
uart_rx_pkg.sv
rx_fifo_rd_if.sv
uart_rx_sampler.sv
uart_rx_fifo.sv
uart_rx_apb.sv
uart_rx_top.sv
tb_uart_rx.sv

// ==== uart_rx_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_rx_top (
	input  wire                                           baud_rx_clock,
	input  wire                                           i_reset,
	input  wire                                           i_rx,
	input  wire                                           i_psel,
	input  wire                                           i_penable,
	input  wire                                           i_pwrite,
	input  wire  [$bits(uart_rx_pkg::ADDR_STATUS)-1:0]    i_paddr,
	input  wire  [31:0]                                   i_pwdata,
	output logic [31:0]                                   o_prdata,
	output logic                                          o_pready,
	output logic                                          o_pslverr
);

	logic       push;
	logic [7:0] rx_byte;
	logic       frame_err;

	rx_fifo_rd_if fifo_rd ();

	uart_rx_sampler u_sampler (
		.baud_rx_clock (baud_rx_clock),
		.i_reset       (i_reset),
		.i_rx          (i_rx),
		.o_push        (push),
		.o_byte        (rx_byte),
		.o_frame_err   (frame_err)
	);

	uart_rx_fifo u_fifo (
		.baud_rx_clock (baud_rx_clock),
		.i_reset       (i_reset),
		.i_push        (push),
		.i_byte        (rx_byte),
		.i_frame_err   (frame_err),
		.rd            (fifo_rd.fifo)
	);

	uart_rx_apb u_apb (
		.baud_rx_clock (baud_rx_clock),
		.i_reset       (i_reset),
		.i_psel        (i_psel),
		.i_penable     (i_penable),
		.i_pwrite      (i_pwrite),
		.i_paddr       (i_paddr),
		.i_pwdata      (i_pwdata),
		.o_prdata      (o_prdata),
		.o_pready      (o_pready),
		.o_pslverr     (o_pslverr),
		.rd            (fifo_rd.reader)
	);

endmodule

`default_nettype wire
